/* idann_pkg.sv */
// shared widths, sequencer states and weight tables for the idann training tile, used by scoped name
package idann_pkg;

  // bit widths of the values that move between blocks
  localparam int X_W      = 4;
  localparam int WEIGHT_W = 8;
  localparam int HIDDEN_W_BITS = 10;
  localparam int FINAL_W  = 23;
  localparam int TARGET_W = 8;

  // number of hidden neurons kept in this build
  localparam int N_HIDDEN = 2;

  // four binary network inputs, bit k is input k
  typedef logic [X_W-1:0] x_t;

  // one unsigned weight
  typedef logic [WEIGHT_W-1:0] weight_t;

  // one hidden neuron value
  // sum of four 8-bit weights fits in 10 bits
  typedef logic [HIDDEN_W_BITS-1:0] hidden_t;

  // output accumulator, w0*h0 + w1*h1
  typedef logic [FINAL_W-1:0] final_t;

  // unsigned training target
  typedef logic [TARGET_W-1:0] target_t;

  // sequencer phases of one training step
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_HIDDEN,
    PH_OUT0,
    PH_OUT1,
    PH_BACK
  } phase_e;

  // fixed input-to-hidden weights
  // row selects the neuron, column k multiplies input bit k
  localparam weight_t HIDDEN_W [N_HIDDEN][X_W] = '{
    '{8'd1, 8'd2, 8'd3, 8'd4},
    '{8'd4, 8'd3, 8'd2, 8'd1}
  };

  // hidden-to-output weight values after reset
  localparam weight_t OUT_W_RESET [N_HIDDEN] = '{8'd1, 8'd2};

  // ceiling for the output weight increment
  localparam weight_t WEIGHT_MAX = 8'd255;

endpackage

/* state_mach.sv */
// training step sequencer, turns a rising start edge into the hidden, output and backprop pulses
module state_mach (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  output logic hidden_en_o,
  output logic out_clear_o,
  output logic out_acc_o,
  output logic back_en_o
);

  // previous start level for edge detection
  logic start_q;
  logic start_rise;

  // current and next phase
  idann_pkg::phase_e phase_q;
  idann_pkg::phase_e phase_d;

  // start is sampled every cycle
  // so a level held high through a busy step never retriggers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_i;
    end
  end

  assign start_rise = start_i & ~start_q;

  // one phase per cycle, only idle listens to start
  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      idann_pkg::PH_IDLE: begin
        if (start_rise) begin
          phase_d = idann_pkg::PH_HIDDEN;
        end
      end
      idann_pkg::PH_HIDDEN: begin
        phase_d = idann_pkg::PH_OUT0;
      end
      idann_pkg::PH_OUT0: begin
        phase_d = idann_pkg::PH_OUT1;
      end
      idann_pkg::PH_OUT1: begin
        phase_d = idann_pkg::PH_BACK;
      end
      idann_pkg::PH_BACK: begin
        phase_d = idann_pkg::PH_IDLE;
      end
      default: begin
        // unused encodings fall back to idle
        phase_d = idann_pkg::PH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= idann_pkg::PH_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  // pulses decoded straight from the phase, one cycle each
  assign hidden_en_o = (phase_q == idann_pkg::PH_HIDDEN);
  assign out_clear_o = (phase_q == idann_pkg::PH_OUT0);
  assign out_acc_o   = (phase_q == idann_pkg::PH_OUT1);
  assign back_en_o   = (phase_q == idann_pkg::PH_BACK);

endmodule

/* hidden_neuron.sv */
// hidden neuron, registers the table-weighted sum of the four input bits on its enable pulse
module hidden_neuron #(
  parameter int NEURON_IDX = 0
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              hidden_en_i,
  input  idann_pkg::x_t     x_i,
  output idann_pkg::hidden_t hidden_o
);

  // combinational sum of the selected weights
  idann_pkg::hidden_t sum;
  idann_pkg::hidden_t hidden_q;

  // binary inputs, so each bit just gates its weight in or out
  always_comb begin
    sum = '0;
    for (int k = 0; k < idann_pkg::X_W; k++) begin
      if (x_i[k]) begin
        sum = sum + idann_pkg::hidden_t'(idann_pkg::HIDDEN_W[NEURON_IDX][k]);
      end
    end
  end

  // value holds between steps
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hidden_q <= '0;
    end else if (hidden_en_i) begin
      hidden_q <= sum;
    end
  end

  assign hidden_o = hidden_q;

endmodule

/* output_neuron.sv */
// output neuron, two-cycle multiply-accumulate of the hidden values with the live output weights
module output_neuron (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               out_clear_i,
  input  logic               out_acc_i,
  input  idann_pkg::hidden_t h0_i,
  input  idann_pkg::hidden_t h1_i,
  input  idann_pkg::weight_t w0_i,
  input  idann_pkg::weight_t w1_i,
  output idann_pkg::final_t  final_o
);

  // one product per phase
  idann_pkg::final_t prod0;
  idann_pkg::final_t prod1;

  // partial sum between the two phases
  idann_pkg::final_t acc_q;

  // registered network output
  idann_pkg::final_t final_q;

  // widen before multiplying so nothing is lost
  assign prod0 = idann_pkg::final_t'(w0_i) * idann_pkg::final_t'(h0_i);
  assign prod1 = idann_pkg::final_t'(w1_i) * idann_pkg::final_t'(h1_i);

  // first phase loads w0*h0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_q <= '0;
    end else if (out_clear_i) begin
      acc_q <= prod0;
    end
  end

  // second phase adds w1*h1 and publishes the result
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      final_q <= '0;
    end else if (out_acc_i) begin
      final_q <= acc_q + prod1;
    end
  end

  // stays put until the next step's second phase
  // backprop reads this while the weights change
  assign final_o = final_q;

endmodule

/* output_backprop.sv */
// hidden-to-output weight register, steps one count toward the target per training step
module output_backprop #(
  parameter int RESET_IDX = 0
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               back_en_i,
  input  idann_pkg::final_t  final_i,
  input  idann_pkg::target_t target_i,
  input  idann_pkg::hidden_t hidden_i,
  output idann_pkg::weight_t w_o
);

  // current weight and its update
  idann_pkg::weight_t w_q;
  idann_pkg::weight_t w_d;

  // target widened to the accumulator width for comparison
  idann_pkg::final_t target_ext;

  assign target_ext = idann_pkg::final_t'(target_i);

  // a zero hidden value means this weight had no effect, so it holds
  always_comb begin
    w_d = w_q;
    if (hidden_i != '0) begin
      if (final_i > target_ext) begin
        // output too big, step down but not below 0
        if (w_q != '0) begin
          w_d = w_q - 1'b1;
        end
      end else if (final_i < target_ext) begin
        // output too small, step up until the ceiling
        if (w_q != idann_pkg::WEIGHT_MAX) begin
          w_d = w_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_q <= idann_pkg::OUT_W_RESET[RESET_IDX];
    end else if (back_en_i) begin
      w_q <= w_d;
    end
  end

  // feeds the output neuron directly
  assign w_o = w_q;

endmodule

/* tt_um_idann.sv */
// tiny tapeout tile top, wires the pins to the sequencer, neurons and output weight updaters
module tt_um_idann (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       ena_i,
  input  logic [7:0] ui_in_i,
  input  logic [7:0] uio_in_i,
  output logic [7:0] uo_out_o,
  output logic [7:0] uio_out_o,
  output logic [7:0] uio_oe_o
);

  // ena_i is high whenever the tile is powered
  // nothing here depends on it

  // phase pulses
  logic hidden_en;
  logic out_clear;
  logic out_acc;
  logic back_en;

  // sample and target straight from the pins
  idann_pkg::x_t      x;
  idann_pkg::target_t target;

  // datapath values
  idann_pkg::hidden_t h0;
  idann_pkg::hidden_t h1;
  idann_pkg::weight_t w0;
  idann_pkg::weight_t w1;
  idann_pkg::final_t  final_val;

  assign x      = ui_in_i[3:0];
  assign target = uio_in_i;

  // ui_in_i[7] is the start level
  state_mach state_mach_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .start_i    (ui_in_i[7]),
    .hidden_en_o(hidden_en),
    .out_clear_o(out_clear),
    .out_acc_o  (out_acc),
    .back_en_o  (back_en)
  );

  hidden_neuron #(.NEURON_IDX(0)) hn0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .hidden_en_i(hidden_en), .x_i(x), .hidden_o(h0)
  );

  hidden_neuron #(.NEURON_IDX(1)) hn1 (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .hidden_en_i(hidden_en), .x_i(x), .hidden_o(h1)
  );

  output_neuron on0 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .out_clear_i(out_clear),
    .out_acc_i  (out_acc),
    .h0_i       (h0),
    .h1_i       (h1),
    .w0_i       (w0),
    .w1_i       (w1),
    .final_o    (final_val)
  );

  // each updater only sees the hidden value its weight multiplies
  output_backprop #(.RESET_IDX(0)) obp0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .back_en_i(back_en),
    .final_i(final_val), .target_i(target), .hidden_i(h0), .w_o(w0)
  );

  output_backprop #(.RESET_IDX(1)) obp1 (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .back_en_i(back_en),
    .final_i(final_val), .target_i(target), .hidden_i(h1), .w_o(w1)
  );

  // low byte of the network output on the dedicated pins
  assign uo_out_o  = final_val[7:0];

  // bidirectional pins stay inputs
  assign uio_out_o = 8'h00;
  assign uio_oe_o  = 8'h00;

endmodule

/* tb_idann.sv */
// self-checking testbench for the idann tile, trains random samples against a reference model
module tb_idann;
  timeunit 1ns;
  timeprecision 100ps;

  // bounds, in clock cycles or training steps
  localparam int LOW_TIMEOUT = 20;
  localparam int N_RANDOM    = 40;
  localparam int MAX_DRAIN   = 300;

  logic       clk;
  logic       arst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  // reference model weights, trained alongside the DUT
  idann_pkg::weight_t mw0;
  idann_pkg::weight_t mw1;

  int seed;
  int checks;
  int errors;
  int timeouts;

  tt_um_idann tt_um_idann_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .ena_i    (ena),
    .ui_in_i  (ui_in),
    .uio_in_i (uio_in),
    .uo_out_o (uo_out),
    .uio_out_o(uio_out),
    .uio_oe_o (uio_oe)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // hidden value from the fixed table, bit k gates weight k
  function automatic idann_pkg::hidden_t model_hidden(input int idx, input idann_pkg::x_t x);
    idann_pkg::hidden_t sum;
    sum = '0;
    for (int k = 0; k < 4; k++) begin
      if (x[k]) begin
        sum = sum + idann_pkg::hidden_t'(idann_pkg::HIDDEN_W[idx][k]);
      end
    end
    return sum;
  endfunction

  // one count toward the target, held when the hidden value is zero
  function automatic idann_pkg::weight_t model_step(input idann_pkg::weight_t w,
      input idann_pkg::hidden_t h, input idann_pkg::final_t f, input idann_pkg::target_t t);
    idann_pkg::weight_t r;
    r = w;
    if (h != '0 && f > idann_pkg::final_t'(t) && w != 8'd0) begin
      r = w - 8'd1;
    end else if (h != '0 && f < idann_pkg::final_t'(t) && w != idann_pkg::WEIGHT_MAX) begin
      r = w + 8'd1;
    end
    return r;
  endfunction

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic report_and_finish();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // true once the registered start reads low and no step is running
  function automatic bit idle_with_start_low();
    return tt_um_idann_i.state_mach_i.start_q === 1'b0 &&
           tt_um_idann_i.state_mach_i.phase_q == idann_pkg::PH_IDLE;
  endfunction

  // drop start and wait, bounded, so the next rise is a fresh edge
  task automatic release_start();
    int cnt;
    cnt = 0;
    @(negedge clk);
    ui_in[7] = 1'b0;
    while (!idle_with_start_low() && cnt < LOW_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!idle_with_start_low()) begin
      timeouts++;
      $display("timeout: start did not read low with the sequencer idle");
      report_and_finish();
    end
  endtask

  // one training step, bump pulses start again while the step runs
  task automatic run_step(input idann_pkg::x_t x, input idann_pkg::target_t t, input bit bump);
    idann_pkg::hidden_t h0;
    idann_pkg::hidden_t h1;
    idann_pkg::final_t  f;
    release_start();
    ui_in  = {1'b1, 3'b000, x};
    uio_in = t;
    h0 = model_hidden(0, x);
    h1 = model_hidden(1, x);
    f  = idann_pkg::final_t'(mw0) * idann_pkg::final_t'(h0) +
         idann_pkg::final_t'(mw1) * idann_pkg::final_t'(h1);
    // edge E is taken at this rising clock
    @(posedge clk);
    for (int cyc = 1; cyc <= 6; cyc++) begin
      @(posedge clk);
      @(negedge clk);
      if (bump && cyc == 1) begin
        ui_in[7] = 1'b0;
      end
      // second rise comes with another sample
      // a restarted step would then give a different output
      if (bump && cyc == 2) begin
        ui_in = {1'b1, 3'b000, x ^ 4'h1};
      end
      // final is registered at E+3 and must hold afterwards
      if (cyc == 3) begin
        check_byte("output three cycles after start", f[7:0], uo_out);
      end
      if (cyc == 6) begin
        check_byte("output held after step", f[7:0], uo_out);
      end
    end
    mw0 = model_step(mw0, h0, f, t);
    mw1 = model_step(mw1, h1, f, t);
  endtask

  initial begin
    idann_pkg::x_t      x;
    idann_pkg::target_t t;
    int                 n;
    clk      = 1'b0;
    arst_n   = 1'b0;
    ena      = 1'b1;
    // sample bits set with start low, a spurious step would show on the output
    ui_in    = 8'h0f;
    uio_in   = 8'h00;
    seed     = 32'h59ad;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    mw0      = idann_pkg::OUT_W_RESET[0];
    mw1      = idann_pkg::OUT_W_RESET[1];
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // no start edge yet, output stays zero
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_byte("output after reset", 8'h00, uo_out);
    end
    check_byte("uio_out tie", 8'h00, uio_out);
    check_byte("uio_oe tie", 8'h00, uio_oe);

    // random samples, one of them with all inputs low
    for (int i = 0; i < N_RANDOM; i++) begin
      x = idann_pkg::x_t'($random(seed));
      t = idann_pkg::target_t'($random(seed));
      if (i == 7) begin
        x = '0;
      end
      run_step(x, t, 1'b0);
    end

    // retrigger while busy must not disturb the step
    run_step(4'h6, 8'd90, 1'b1);
    run_step(4'h9, 8'd40, 1'b0);

    // high target, weights climb
    for (int i = 0; i < 12; i++) begin
      run_step(4'h1, 8'd255, 1'b0);
    end

    // zero target with both hidden values nonzero, weights drain
    n = 0;
    while ((mw0 != 8'd0 || mw1 != 8'd0) && n < MAX_DRAIN) begin
      run_step(4'hf, 8'd0, 1'b0);
      n++;
    end
    if (mw0 != 8'd0 || mw1 != 8'd0) begin
      timeouts++;
      $display("timeout: model weights did not reach zero");
    end
    run_step(4'hf, 8'd0, 1'b0);
    check_byte("output with both weights at zero", 8'h00, uo_out);

    report_and_finish();
  end

endmodule

/* list.f */
idann_pkg.sv
state_mach.sv
hidden_neuron.sv
output_neuron.sv
output_backprop.sv
tt_um_idann.sv
tb_idann.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing
TOP      = tb_idann
RTL_TOP  = tt_um_idann
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(TOP)

# pass or fail comes from the log, not from the simulator exit code
sim:
	rm -f $(LOG)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
